// ==== source/rvBack_cfg.svh ====
`ifndef RVBACK_CFG_SVH
`define RVBACK_CFG_SVH

// Data path width
`define XLEN 32

// Data memory depth in 32-bit words, must be a power of two
`define DMEM_WORDS 1024

`endif

// ==== source/rvBackPkg.sv ====
package rvBackPkg;

	// Writeback source chosen by the execute stage
	typedef enum logic [1:0] {
		wbAlu     = 2'd0,
		wbLoad    = 2'd1,
		wbPcPlus4 = 2'd2,
		wbJump    = 2'd3
	} wbSelT;

	// Memory access width, encoded as the load/store funct3 field
	typedef enum logic [2:0] {
		accByte  = 3'b000,
		accHalf  = 3'b001,
		accWord  = 3'b010,
		accByteU = 3'b100, // LBU
		accHalfU = 3'b101  // LHU
	} accessT;

	// Major opcodes that separate loads from stores
	localparam logic [6:0] opLoad  = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;

endpackage

// ==== source/execMemReg.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module execMemReg (
	input  logic                clk,
	input  logic                rst,

	input  logic [2:0]          funct3E,
	input  logic [`XLEN-1:0]    aluOutE,
	input  logic [`XLEN-1:0]    forwardRs2E,
	input  logic [`XLEN-1:0]    pcPlus4E,
	input  logic [`XLEN-1:0]    jumpResultPlus4E,
	input  logic [6:0]          opcodeE,
	input  logic                memAccessE,
	input  rvBackPkg::wbSelT    wbSelE,
	input  logic                regWriteE,
	input  logic [4:0]          rdE,

	output logic [2:0]          funct3M,
	output logic [`XLEN-1:0]    aluOutM,
	output logic [`XLEN-1:0]    forwardRs2M,
	output logic [`XLEN-1:0]    pcPlus4M,
	output logic [`XLEN-1:0]    jumpResultPlus4M,
	output logic [6:0]          opcodeM,
	output logic                memAccessM,
	output rvBackPkg::wbSelT    wbSelM,
	output logic                regWriteM,
	output logic [4:0]          rdM
);

	// Control bits, cleared so a reset bubble can not touch memory or registers
	always_ff @(posedge clk) begin
		if (rst) begin
			memAccessM <= 1'b0;
			regWriteM  <= 1'b0;
		end else begin
			memAccessM <= memAccessE;
			regWriteM  <= regWriteE;
		end
	end

	// Payload fields
	always_ff @(posedge clk) begin
		funct3M          <= funct3E;
		aluOutM          <= aluOutE;
		forwardRs2M      <= forwardRs2E;
		pcPlus4M         <= pcPlus4E;
		jumpResultPlus4M <= jumpResultPlus4E;
		opcodeM          <= opcodeE;
		wbSelM           <= wbSelE;
		rdM              <= rdE;
	end

endmodule

// ==== source/dataMemory.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module dataMemory (
	input  logic                            clk,
	input  logic [$clog2(`DMEM_WORDS)-1:0]  wordAddr,
	input  logic [`XLEN-1:0]                writeData,
	input  logic [3:0]                      byteEnable,
	output logic [`XLEN-1:0]                readData
);

	logic [`XLEN-1:0] mem [`DMEM_WORDS];

	always_ff @(posedge clk) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (byteEnable[lane]) begin
				mem[wordAddr][lane*8 +: 8] <= writeData[lane*8 +: 8];
			end
		end
	end

	// Read sees the word as it stood before this edge's write
	always_ff @(posedge clk) begin
		readData <= mem[wordAddr];
	end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module memoryStage (
	input  logic                clk,
	input  logic                rst,

	input  logic [2:0]          funct3M,
	input  logic [`XLEN-1:0]    aluOutM,
	input  logic [`XLEN-1:0]    forwardRs2M,
	input  logic [`XLEN-1:0]    pcPlus4M,
	input  logic [`XLEN-1:0]    jumpResultPlus4M,
	input  logic [6:0]          opcodeM,
	input  logic                memAccessM,
	input  rvBackPkg::wbSelT    wbSelM,
	input  logic                regWriteM,
	input  logic [4:0]          rdM,

	output logic [2:0]          funct3W,
	output logic [`XLEN-1:0]    aluOutW,
	output logic [`XLEN-1:0]    pcPlus4W,
	output logic [`XLEN-1:0]    jumpResultPlus4W,
	output rvBackPkg::wbSelT    wbSelW,
	output logic                regWriteW,
	output logic [4:0]          rdW,
	output logic [`XLEN-1:0]    loadData
);

	localparam int AW = $clog2(`DMEM_WORDS);

	rvBackPkg::accessT  accessM, accessW;
	logic               isStore;
	logic [`XLEN-1:0]   storeData;
	logic [3:0]         byteEnable;
	logic [`XLEN-1:0]   readData;
	logic [`XLEN-1:0]   laneByte, laneHalf;
	logic               memAccessW;

	assign accessM = rvBackPkg::accessT'(funct3M);
	assign accessW = rvBackPkg::accessT'(funct3W);
	assign isStore = memAccessM && (opcodeM == rvBackPkg::opStore);

	// Move the store operand into its byte lanes
	always_comb begin
		case (accessM)
			rvBackPkg::accByte, rvBackPkg::accByteU: begin
				storeData  = forwardRs2M << {aluOutM[1:0], 3'b000};
				byteEnable = 4'b0001 << aluOutM[1:0];
			end
			rvBackPkg::accHalf, rvBackPkg::accHalfU: begin
				storeData  = forwardRs2M << {aluOutM[1], 4'b0000};
				byteEnable = 4'b0011 << {aluOutM[1], 1'b0};
			end
			default: begin
				storeData  = forwardRs2M;
				byteEnable = 4'b1111;
			end
		endcase
		if (!isStore)
			byteEnable = 4'b0000;
	end

	dataMemory dmem (
		.clk        (clk),
		.wordAddr   (aluOutM[AW+1:2]),
		.writeData  (storeData),
		.byteEnable (byteEnable),
		.readData   (readData)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW  <= 1'b0;
			memAccessW <= 1'b0;
		end else begin
			regWriteW  <= regWriteM;
			memAccessW <= memAccessM;
		end
	end

	always_ff @(posedge clk) begin
		funct3W          <= funct3M;
		aluOutW          <= aluOutM; // Low bits pick the lane on the load side
		pcPlus4W         <= pcPlus4M;
		jumpResultPlus4W <= jumpResultPlus4M;
		wbSelW           <= wbSelM;
		rdW              <= rdM;
	end

	assign laneByte = readData >> {aluOutW[1:0], 3'b000};
	assign laneHalf = readData >> {aluOutW[1], 4'b0000};

	always_comb begin
		loadData = '0;
		if (memAccessW) begin
			case (accessW)
				rvBackPkg::accByte:  loadData = {{(`XLEN-8){laneByte[7]}}, laneByte[7:0]};
				rvBackPkg::accByteU: loadData = {{(`XLEN-8){1'b0}}, laneByte[7:0]};
				rvBackPkg::accHalf:  loadData = {{(`XLEN-16){laneHalf[15]}}, laneHalf[15:0]};
				rvBackPkg::accHalfU: loadData = {{(`XLEN-16){1'b0}}, laneHalf[15:0]};
				default:             loadData = readData;
			endcase
		end
	end

endmodule

// ==== source/writebackStage.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module writebackStage (
	input  logic [`XLEN-1:0]    aluOutW,
	input  logic [`XLEN-1:0]    pcPlus4W,
	input  logic [`XLEN-1:0]    jumpResultPlus4W,
	input  rvBackPkg::wbSelT    wbSelW,
	input  logic                regWriteW,
	input  logic [4:0]          rdW,
	input  logic [`XLEN-1:0]    loadData,

	// Register file write port
	output logic                rfWe,
	output logic [4:0]          rfAddr,
	output logic [`XLEN-1:0]    rfData,

	// Bypass back to execute
	output logic [`XLEN-1:0]    wbValue,
	output logic [4:0]          wbRd,
	output logic                wbWrite
);

	logic [`XLEN-1:0] result;
	logic             doWrite;

	always_comb begin
		case (wbSelW)
			rvBackPkg::wbAlu:     result = aluOutW;
			rvBackPkg::wbLoad:    result = loadData;
			rvBackPkg::wbPcPlus4: result = pcPlus4W;
			rvBackPkg::wbJump:    result = jumpResultPlus4W;
			default:              result = aluOutW;
		endcase
	end

	// Writes to x0 are dropped here and nowhere else
	assign doWrite = regWriteW && (rdW != 5'd0);

	assign rfWe    = doWrite;
	assign rfAddr  = rdW;
	assign rfData  = result;

	assign wbValue = result;
	assign wbRd    = rdW;
	assign wbWrite = doWrite;

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module regFile (
	input  logic                clk,
	input  logic                we,
	input  logic [4:0]          waddr,
	input  logic [`XLEN-1:0]    wdata,
	input  logic [4:0]          raddr1,
	input  logic [4:0]          raddr2,
	output logic [`XLEN-1:0]    rdata1,
	output logic [`XLEN-1:0]    rdata2
);

	// Entry 0 is never written since the write enable already excludes x0
	logic [`XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (we)
			regs[waddr] <= wdata;
	end

	// Same-cycle write is not visible here, the bypass covers it
	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== source/rvBackEnd.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module rvBackEnd (
	input  logic                clk,
	input  logic                rst,

	input  logic [2:0]          funct3E,
	input  logic [`XLEN-1:0]    aluOutE,
	input  logic [`XLEN-1:0]    forwardRs2E,
	input  logic [`XLEN-1:0]    pcPlus4E,
	input  logic [`XLEN-1:0]    jumpResultPlus4E,
	input  logic [6:0]          opcodeE,
	input  logic                memAccessE,
	input  rvBackPkg::wbSelT    wbSelE,
	input  logic                regWriteE,
	input  logic [4:0]          rdE,

	input  logic [4:0]          rs1Addr,
	input  logic [4:0]          rs2Addr,
	output logic [`XLEN-1:0]    rs1Data,
	output logic [`XLEN-1:0]    rs2Data,

	output logic [`XLEN-1:0]    wbValue,
	output logic [4:0]          wbRd,
	output logic                wbWrite
);

	logic [2:0]         funct3M;
	logic [`XLEN-1:0]   aluOutM, forwardRs2M, pcPlus4M, jumpResultPlus4M;
	logic [6:0]         opcodeM;
	logic               memAccessM, regWriteM;
	rvBackPkg::wbSelT   wbSelM;
	logic [4:0]         rdM;

	logic [`XLEN-1:0]   aluOutW, pcPlus4W, jumpResultPlus4W, loadData;
	rvBackPkg::wbSelT   wbSelW;
	logic               regWriteW;
	logic [4:0]         rdW;

	logic               rfWe;
	logic [4:0]         rfAddr;
	logic [`XLEN-1:0]   rfData;

	execMemReg exMem (
		.clk, .rst,
		.funct3E, .aluOutE, .forwardRs2E, .pcPlus4E, .jumpResultPlus4E,
		.opcodeE, .memAccessE, .wbSelE, .regWriteE, .rdE,
		.funct3M, .aluOutM, .forwardRs2M, .pcPlus4M, .jumpResultPlus4M,
		.opcodeM, .memAccessM, .wbSelM, .regWriteM, .rdM
	);

	memoryStage memStage (
		.clk, .rst,
		.funct3M, .aluOutM, .forwardRs2M, .pcPlus4M, .jumpResultPlus4M,
		.opcodeM, .memAccessM, .wbSelM, .regWriteM, .rdM,
		.funct3W          (), // Width code is consumed by the load extractor inside
		.aluOutW, .pcPlus4W, .jumpResultPlus4W, .wbSelW, .regWriteW, .rdW,
		.loadData
	);

	writebackStage wbStage (
		.aluOutW, .pcPlus4W, .jumpResultPlus4W, .wbSelW, .regWriteW, .rdW,
		.loadData,
		.rfWe, .rfAddr, .rfData,
		.wbValue, .wbRd, .wbWrite
	);

	regFile rf (
		.clk,
		.we     (rfWe),
		.waddr  (rfAddr),
		.wdata  (rfData),
		.raddr1 (rs1Addr),
		.raddr2 (rs2Addr),
		.rdata1 (rs1Data),
		.rdata2 (rs2Data)
	);

endmodule

// ==== verification/rvBackEnd_chk.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module rvBackEnd_chk (
	input  logic                clk,
	input  logic                rst,
	input  logic                wbWrite,
	input  logic [4:0]          wbRd,
	input  logic [4:0]          rs1Addr,
	input  logic [4:0]          rs2Addr,
	input  logic [`XLEN-1:0]    rs1Data,
	input  logic [`XLEN-1:0]    rs2Data
);

	int assertFails = 0;

	noZeroWrite: assert property (@(posedge clk) disable iff (rst) wbWrite |-> wbRd != 5'd0)
		else begin
			$error("Bypass reports a write to x0");
			assertFails++;
		end

	// Reset clears both control stages, so two quiet cycles follow
	quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbWrite ##1 !wbWrite)
		else begin
			$error("Writeback active right after reset release");
			assertFails++;
		end

	zeroRegister: assert property (@(posedge clk)
		(rs1Addr != 5'd0 || rs1Data == '0) && (rs2Addr != 5'd0 || rs2Data == '0))
		else begin
			$error("Read of x0 returned a nonzero value");
			assertFails++;
		end

endmodule

bind rvBackEnd rvBackEnd_chk chk (
	.clk, .rst, .wbWrite, .wbRd, .rs1Addr, .rs2Addr, .rs1Data, .rs2Data
);

// ==== verification/rvBackEnd_monitor.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module rvBackEnd_monitor (
	input  logic                clk,
	input  logic                rst,
	input  logic [2:0]          funct3E,
	input  logic [`XLEN-1:0]    aluOutE,
	input  logic [`XLEN-1:0]    forwardRs2E,
	input  logic [`XLEN-1:0]    pcPlus4E,
	input  logic [`XLEN-1:0]    jumpResultPlus4E,
	input  logic [6:0]          opcodeE,
	input  logic                memAccessE,
	input  rvBackPkg::wbSelT    wbSelE,
	input  logic                regWriteE,
	input  logic [4:0]          rdE,
	input  logic [4:0]          rs1Addr,
	input  logic [4:0]          rs2Addr,
	input  logic [`XLEN-1:0]    rs1Data,
	input  logic [`XLEN-1:0]    rs2Data,
	input  logic [`XLEN-1:0]    wbValue,
	input  logic [4:0]          wbRd,
	input  logic                wbWrite,
	output int                  checkCount,
	output int                  errorCount
);

	localparam int AW = $clog2(`DMEM_WORDS);

	typedef struct packed {
		logic             valid;
		logic [2:0]       funct3;
		logic [`XLEN-1:0] aluOut;
		logic [`XLEN-1:0] rs2;
		logic [`XLEN-1:0] pcPlus4;
		logic [`XLEN-1:0] jump;
		logic [6:0]       opcode;
		logic             memAccess;
		rvBackPkg::wbSelT wbSel;
		logic             regWrite;
		logic [4:0]       rd;
		logic [`XLEN-1:0] expValue;
	} instT;

	instT             instM, instW;
	logic [`XLEN-1:0] regModel [32];
	logic [31:0]      regKnown;
	logic [`XLEN-1:0] memModel [`DMEM_WORDS];
	int               edges;

	// Expected writeback value, and the addressed word after any store
	function automatic logic [`XLEN-1:0] expectedResult(input instT inst,
		input logic [`XLEN-1:0] oldWord, output logic [`XLEN-1:0] newWord);
		logic [1:0]       off;
		logic [7:0]       b;
		logic [15:0]      h;
		logic [`XLEN-1:0] loadVal;
		off = inst.aluOut[1:0];
		b = oldWord[8*off +: 8];
		h = oldWord[16*off[1] +: 16];
		newWord = oldWord;
		if (inst.memAccess && inst.opcode == rvBackPkg::opStore) begin
			case (inst.funct3)
				rvBackPkg::accByte, rvBackPkg::accByteU: newWord[8*off +: 8] = inst.rs2[7:0];
				rvBackPkg::accHalf, rvBackPkg::accHalfU: newWord[16*off[1] +: 16] = inst.rs2[15:0];
				default: newWord = inst.rs2;
			endcase
		end
		case (inst.funct3)
			rvBackPkg::accByte:  loadVal = {{(`XLEN-8){b[7]}}, b};
			rvBackPkg::accByteU: loadVal = {{(`XLEN-8){1'b0}}, b};
			rvBackPkg::accHalf:  loadVal = {{(`XLEN-16){h[15]}}, h};
			rvBackPkg::accHalfU: loadVal = {{(`XLEN-16){1'b0}}, h};
			default:             loadVal = oldWord;
		endcase
		if (!inst.memAccess)
			loadVal = '0;
		case (inst.wbSel)
			rvBackPkg::wbLoad:    return loadVal;
			rvBackPkg::wbPcPlus4: return inst.pcPlus4;
			rvBackPkg::wbJump:    return inst.jump;
			default:              return inst.aluOut;
		endcase
	endfunction

	task automatic compare(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	initial begin
		checkCount = 0;
		errorCount = 0;
		edges = 0;
		regKnown = '0;
		instM = '0;
		instW = '0;
	end

	always @(posedge clk) begin
		logic [`XLEN-1:0] newWord;
		logic             wantWrite;
		edges++;
		wantWrite = instW.valid && instW.regWrite && instW.rd != 5'd0;
		if (edges > 1) begin
			compare("wbWrite", wbWrite, wantWrite);
			if (instW.valid) begin
				compare("wbRd", wbRd, instW.rd);
				compare("wbValue", wbValue, instW.expValue);
			end
			if (rs1Addr == 5'd0 || regKnown[rs1Addr])
				compare("rs1Data", rs1Data, (rs1Addr == 5'd0) ? '0 : regModel[rs1Addr]);
			if (rs2Addr == 5'd0 || regKnown[rs2Addr])
				compare("rs2Data", rs2Data, (rs2Addr == 5'd0) ? '0 : regModel[rs2Addr]);
		end
		if (wantWrite) begin // Register file takes this on the same edge
			regModel[instW.rd] = instW.expValue;
			regKnown[instW.rd] = 1'b1;
		end
		if (instM.valid) begin
			instM.expValue = expectedResult(instM, memModel[instM.aluOut[AW+1:2]], newWord);
			memModel[instM.aluOut[AW+1:2]] = newWord;
		end
		if (rst)
			instM.valid = 1'b0; // Memory was still touched, but W control is cleared
		instW = instM;
		instM.valid     = !rst;
		instM.funct3    = funct3E;
		instM.aluOut    = aluOutE;
		instM.rs2       = forwardRs2E;
		instM.pcPlus4   = pcPlus4E;
		instM.jump      = jumpResultPlus4E;
		instM.opcode    = opcodeE;
		instM.memAccess = memAccessE;
		instM.wbSel     = wbSelE;
		instM.regWrite  = regWriteE;
		instM.rd        = rdE;
	end

endmodule

// ==== verification/rvBackEnd_tb.sv ====
`timescale 1ns/1ns
`include "rvBack_cfg.svh"

module rvBackEnd_tb;

	localparam int resetCycles = 8;
	localparam int nIssued     = 110; // Upper bound on instructions over all tests
	localparam int drainCycles = 3 + 32 + 2; // Pipeline drain, register sweep and settle
	localparam int nTests      = 6;
	localparam int runCycles   = 2 * resetCycles + nIssued + nTests * drainCycles;
	localparam logic [`XLEN-1:0] knownAddr = 32'h0000_0100;

	logic               clk = 1'b0;
	logic               rst;
	logic [2:0]         funct3E;
	logic [`XLEN-1:0]   aluOutE, forwardRs2E, pcPlus4E, jumpResultPlus4E;
	logic [6:0]         opcodeE;
	logic               memAccessE, regWriteE;
	rvBackPkg::wbSelT   wbSelE;
	logic [4:0]         rdE;
	logic [4:0]         rs1Addr, rs2Addr;
	logic [`XLEN-1:0]   rs1Data, rs2Data, wbValue;
	logic [4:0]         wbRd;
	logic               wbWrite;

	int checkCount, errorCount;
	int testCount, failedTests, chkBase, errBase;

	always #5 clk = ~clk;

	rvBackEnd uut (.*);

	rvBackEnd_monitor mon (.*);

	task automatic drive(input logic [2:0] f3, input logic [`XLEN-1:0] alu,
		input logic [`XLEN-1:0] data, input logic [6:0] op, input logic mem,
		input rvBackPkg::wbSelT sel, input logic we, input logic [4:0] rd);
		@(posedge clk);
		funct3E          <= f3;
		aluOutE          <= alu;
		forwardRs2E      <= data;
		opcodeE          <= op;
		memAccessE       <= mem;
		wbSelE           <= sel;
		regWriteE        <= we;
		rdE              <= rd;
		pcPlus4E         <= $urandom; // Every instruction carries fresh link values
		jumpResultPlus4E <= $urandom;
	endtask

	task automatic bubble(input int n);
		repeat (n) drive(3'd0, '0, '0, 7'd0, 1'b0, rvBackPkg::wbAlu, 1'b0, 5'd0);
	endtask

	function automatic logic [4:0] randomRd();
		return 5'(1 + $urandom % 31);
	endfunction

	// Drain the pipeline, sweep both read ports over all registers, then report
	task automatic closeTest(input string name);
		int errs;
		bubble(3);
		for (int i = 0; i < 32; i++) begin
			@(posedge clk);
			rs1Addr <= 5'(i);
			rs2Addr <= 5'(31 - i);
		end
		@(posedge clk);
		@(negedge clk);
		errs = errorCount - errBase;
		testCount++;
		if (errs != 0)
			failedTests++;
		$display("Test %0d %s: %0d checks, %0d errors", testCount, name,
			checkCount - chkBase, errs);
		chkBase = checkCount;
		errBase = errorCount;
	endtask

	initial begin
		logic [`XLEN-1:0] addrs [8];
		void'($urandom(32'hdafc_e1bb));
		rst = 1'b1;
		funct3E = '0; aluOutE = '0; forwardRs2E = '0; pcPlus4E = '0;
		jumpResultPlus4E = '0; opcodeE = '0; memAccessE = 1'b0; regWriteE = 1'b0;
		wbSelE = rvBackPkg::wbAlu; rdE = '0; rs1Addr = '0; rs2Addr = '0;
		testCount = 0; failedTests = 0; chkBase = 0; errBase = 0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < 24; i++)
			drive(3'd0, $urandom, $urandom, 7'b0110011, 1'b0, rvBackPkg::wbAlu, 1'b1, randomRd());
		closeTest("alu writeback");

		for (int i = 0; i < 8; i++) begin
			addrs[i] = $urandom & 32'hffff_fffc; // Upper bits beyond the memory wrap
			drive(rvBackPkg::accWord, addrs[i], $urandom, rvBackPkg::opStore, 1'b1,
				rvBackPkg::wbAlu, 1'b0, 5'd0);
		end
		for (int i = 0; i < 8; i++)
			drive(rvBackPkg::accWord, addrs[i], '0, rvBackPkg::opLoad, 1'b1,
				rvBackPkg::wbLoad, 1'b1, randomRd());
		for (int i = 0; i < 4; i++) begin
			drive(rvBackPkg::accWord, addrs[i], $urandom, rvBackPkg::opStore, 1'b1,
				rvBackPkg::wbAlu, 1'b0, 5'd0);
			drive(rvBackPkg::accWord, addrs[i], '0, rvBackPkg::opLoad, 1'b1,
				rvBackPkg::wbLoad, 1'b1, randomRd()); // Back to back with its store
		end
		closeTest("word store and load");

		drive(rvBackPkg::accWord, knownAddr, 32'h8081_7f02, rvBackPkg::opStore, 1'b1,
			rvBackPkg::wbAlu, 1'b0, 5'd0);
		drive(rvBackPkg::accByte, knownAddr + 1, 32'h1234_56aa, rvBackPkg::opStore, 1'b1,
			rvBackPkg::wbAlu, 1'b0, 5'd0);
		drive(rvBackPkg::accHalf, knownAddr + 2, 32'hdead_9155, rvBackPkg::opStore, 1'b1,
			rvBackPkg::wbAlu, 1'b0, 5'd0);
		for (int off = 0; off < 4; off++) begin
			drive(rvBackPkg::accByte, knownAddr + off, '0, rvBackPkg::opLoad, 1'b1,
				rvBackPkg::wbLoad, 1'b1, randomRd());
			drive(rvBackPkg::accByteU, knownAddr + off, '0, rvBackPkg::opLoad, 1'b1,
				rvBackPkg::wbLoad, 1'b1, randomRd());
		end
		for (int off = 0; off < 4; off += 2) begin
			drive(rvBackPkg::accHalf, knownAddr + off, '0, rvBackPkg::opLoad, 1'b1,
				rvBackPkg::wbLoad, 1'b1, randomRd());
			drive(rvBackPkg::accHalfU, knownAddr + off, '0, rvBackPkg::opLoad, 1'b1,
				rvBackPkg::wbLoad, 1'b1, randomRd());
		end
		drive(rvBackPkg::accWord, knownAddr, '0, rvBackPkg::opLoad, 1'b1,
			rvBackPkg::wbLoad, 1'b1, randomRd());
		closeTest("narrow access");

		for (int i = 0; i < 8; i++)
			drive(3'd0, $urandom, '0, 7'b1101111, 1'b0,
				(i % 2 != 0) ? rvBackPkg::wbJump : rvBackPkg::wbPcPlus4, 1'b1, randomRd());
		closeTest("link values");

		for (int i = 0; i < 4; i++)
			drive(3'd0, $urandom, '0, 7'b0110011, 1'b0, rvBackPkg::wbAlu, 1'b0, randomRd());
		for (int i = 0; i < 4; i++)
			drive(3'd0, $urandom, '0, 7'b0110011, 1'b0, rvBackPkg::wbAlu, 1'b1, 5'd0);
		drive(rvBackPkg::accWord, knownAddr + 4, $urandom, rvBackPkg::opStore, 1'b1,
			rvBackPkg::wbAlu, 1'b0, 5'd0);
		drive(rvBackPkg::accWord, knownAddr + 4, '0, rvBackPkg::opLoad, 1'b1,
			rvBackPkg::wbLoad, 1'b0, randomRd());
		drive(rvBackPkg::accWord, knownAddr + 4, '0, rvBackPkg::opLoad, 1'b1,
			rvBackPkg::wbLoad, 1'b1, randomRd());
		closeTest("suppressed writes");

		// Live stores and register writes while reset is held
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < 7; i++)
			drive(rvBackPkg::accWord, knownAddr, 32'hffff_ffff, rvBackPkg::opStore, 1'b1,
				rvBackPkg::wbAlu, 1'b1, 5'(i + 1));
		bubble(1);
		rst <= 1'b0;
		drive(rvBackPkg::accWord, knownAddr, '0, rvBackPkg::opLoad, 1'b1,
			rvBackPkg::wbLoad, 1'b1, randomRd());
		closeTest("reset suppression");

		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			testCount, failedTests, checkCount, errorCount, uut.chk.assertFails);
		if (errorCount == 0 && uut.chk.assertFails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		#(runCycles * 10 * 2);
		$display("Watchdog expired after %0d ns before the tests completed", runCycles * 20);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+source
source/rvBackPkg.sv
source/execMemReg.sv
source/dataMemory.sv
source/memoryStage.sv
source/writebackStage.sv
source/regFile.sv
source/rvBackEnd.sv
verification/rvBackEnd_chk.sv
verification/rvBackEnd_monitor.sv
verification/rvBackEnd_tb.sv

// ==== Bender.yml ====
package:
  name: rv_back_end

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rvBackPkg.sv
      - source/execMemReg.sv
      - source/dataMemory.sv
      - source/memoryStage.sv
      - source/writebackStage.sv
      - source/regFile.sv
      - source/rvBackEnd.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/rvBackEnd_chk.sv
      - verification/rvBackEnd_monitor.sv
      - verification/rvBackEnd_tb.sv
